// File: Makefile
.PHONY: all run lint clean

all: run

run: obj_dir/Vhsid_main_tb
	./obj_dir/Vhsid_main_tb | tee sim.log
	grep -q "^all tests passed$$" sim.log

obj_dir/Vhsid_main_tb: all.f $(wildcard *.sv)
	verilator --binary -j 0 -f all.f --top-module hsid_main_tb

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module hsid_main

clean:
	rm -rf obj_dir sim.log

// File: all.f
hsid_pkg.sv
hsid_fifo.sv
hsid_main_fsm.sv
hsid_mse.sv
hsid_mse_comp.sv
hsid_main.sv
hsid_main_tb.sv

// File: hsid_cases.txt
# header: name lib_size min_ref min_value max_ref max_value (size and refs decimal, values hex)
# then measured spectrum and each reference, one line of four hex words, low half = even band
copy 3 1 00000000 2 00000100
00200010 00400030 00600050 00800070
00280018 00480038 00680058 00880078
00200010 00400030 00600050 00800070
00300020 00500040 00700060 00900080
mixed 4 2 00000009 3 1c1fc400
10001000 10001000 10001000 10001000
10001100 10001000 10001000 10001000
0f000f00 0f000f00 0f000f00 0f000f00
10031003 10031003 10031003 10031003
10001000 10001000 ffff1000 10001000
ties 4 0 00000001 1 00000010
00000000 00000000 00000000 00000000
00010001 00010001 00010001 00010001
00040004 00040004 00040004 00040004
00020002 00000000 00000000 00000000
00000000 00000000 00000000 00080008
single 1 0 00000003 0 00000003
00640064 00640064 00640064 00640064
00670068 00640064 00640064 00640064
full16 16 13 00000001 9 00000100
01000100 01000100 01000100 01000100
01060106 01060106 01060106 01060106
01090109 01090109 01090109 01090109
01030103 01030103 01030103 01030103
010c010c 010c010c 010c010c 010c010c
01050105 01050105 01050105 01050105
010e010e 010e010e 010e010e 010e010e
01020102 01020102 01020102 01020102
010a010a 010a010a 010a010a 010a010a
01070107 01070107 01070107 01070107
01100110 01100110 01100110 01100110
01040104 01040104 01040104 01040104
010b010b 010b010b 010b010b 010b010b
01080108 01080108 01080108 01080108
01010101 01010101 01010101 01010101
010d010d 010d010d 010d010d 010d010d
010f010f 010f010f 010f010f 010f010f

// File: hsid_fifo.sv
module hsid_fifo #(
  parameter int DEPTH = 4  // Number of words held
) (
  input  logic clk,
  input  logic rst,
  input  logic wr_en,  // Push data_in
  input  logic rd_en,  // Pop the head word
  input  hsid_pkg::word_t data_in,
  output hsid_pkg::word_t data_out,  // Head word, valid when not empty
  output logic full,
  output logic empty
);

  typedef logic [$clog2(DEPTH)-1:0] ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  hsid_pkg::word_t mem [DEPTH];  // Storage array
  ptr_t wr_ptr;  // Next slot to write
  ptr_t rd_ptr;  // Current head slot
  cnt_t count;  // Words stored
  logic do_rd;
  logic do_wr;

  assign full = (count == cnt_t'(DEPTH));
  assign empty = (count == '0);

  assign do_rd = rd_en && !empty;  // Pop only real data
  assign do_wr = wr_en && (!full || do_rd);  // A pop makes room for a push when full

  assign data_out = mem[rd_ptr];  // Fall-through head

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + ptr_t'(1);  // Wrap
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + ptr_t'(1);  // Wrap
      end
      if (do_wr && !do_rd) begin
        count <= count + cnt_t'(1);
      end else if (do_rd && !do_wr) begin
        count <= count - cnt_t'(1);
      end
    end
  end

endmodule

// File: hsid_main.sv
module hsid_main (
  input  logic clk,
  input  logic rst,
  input  logic hsi_vctr_in_valid,  // Input word strobe
  input  hsid_pkg::word_t hsi_vctr_in,  // Two packed band samples
  input  hsid_pkg::lib_size_t library_size_in,  // Held from start to done
  input  logic clear,  // Reset stored min and max
  input  logic start,
  output hsid_pkg::lib_ref_t mse_min_ref,
  output hsid_pkg::word_t mse_min_value,
  output hsid_pkg::lib_ref_t mse_max_ref,
  output hsid_pkg::word_t mse_max_value,
  output logic done,
  output logic idle,
  output logic ready
);

  hsid_pkg::hsid_main_state_t state;
  logic fifo_measure_full;
  logic fifo_measure_empty;
  logic fifo_ref_full;
  logic fifo_ref_empty;
  logic fifo_measure_wr_en;
  logic fifo_ref_wr_en;
  logic fifo_both_read_en;  // Pop a measure and ref pair
  hsid_pkg::word_t fifo_measure_data_in;
  hsid_pkg::word_t fifo_measure_data_out;
  hsid_pkg::word_t fifo_ref_data_out;
  logic element_start;
  logic element_last;
  logic element_valid;
  hsid_pkg::lib_ref_t vctr_ref;  // Index of the pair in flight
  logic recirc;  // Push the popped measure word back
  hsid_pkg::word_t mse_out;
  hsid_pkg::lib_ref_t mse_ref;
  logic mse_valid;
  logic mse_cmp_valid;  // Comparator result strobe

  // Last vector does not recirculate, leaving the measure FIFO empty for the next run
  assign recirc = fifo_both_read_en &&
                  (hsid_pkg::lib_size_t'(vctr_ref) != library_size_in - hsid_pkg::lib_size_t'(1));

  assign fifo_measure_data_in = (state == hsid_pkg::READ_MEASURE) ? hsi_vctr_in :
                                fifo_measure_data_out;
  assign fifo_measure_wr_en = (state == hsid_pkg::READ_MEASURE) ? (hsi_vctr_in_valid && ready) :
                              recirc;
  assign fifo_ref_wr_en = (state == hsid_pkg::COMPUTE_MSE) && hsi_vctr_in_valid && ready;

  hsid_main_fsm fsm (
    .clk(clk),
    .rst(rst),
    .start(start),
    .library_size(library_size_in),
    .in_valid(hsi_vctr_in_valid),
    .fifo_measure_full(fifo_measure_full),
    .fifo_measure_empty(fifo_measure_empty),
    .fifo_ref_full(fifo_ref_full),
    .fifo_ref_empty(fifo_ref_empty),
    .mse_cmp_valid(mse_cmp_valid),
    .state(state),
    .vctr_count(vctr_ref),
    .element_start(element_start),
    .element_last(element_last),
    .element_valid(element_valid),
    .fifo_both_read_en(fifo_both_read_en),
    .done(done),
    .idle(idle),
    .ready(ready)
  );

  hsid_fifo #(.DEPTH(hsid_pkg::ELEMENTS)) fifo_measure (  // Holds one spectrum
    .clk(clk),
    .rst(rst),
    .wr_en(fifo_measure_wr_en),
    .rd_en(fifo_both_read_en),
    .data_in(fifo_measure_data_in),
    .data_out(fifo_measure_data_out),
    .full(fifo_measure_full),
    .empty(fifo_measure_empty)
  );

  hsid_fifo #(.DEPTH(hsid_pkg::BUFFER_LENGTH)) fifo_ref (
    .clk(clk),
    .rst(rst),
    .wr_en(fifo_ref_wr_en),
    .rd_en(fifo_both_read_en),
    .data_in(hsi_vctr_in),
    .data_out(fifo_ref_data_out),
    .full(fifo_ref_full),
    .empty(fifo_ref_empty)
  );

  hsid_mse hsi_mse (
    .clk(clk),
    .rst(rst),
    .element_valid(element_valid),
    .element_start(element_start),
    .element_last(element_last),
    .vctr_ref(vctr_ref),
    .element_a(fifo_measure_data_out),
    .element_b(fifo_ref_data_out),
    .mse_value(mse_out),
    .mse_ref(mse_ref),
    .mse_valid(mse_valid)
  );

  hsid_mse_comp hsi_mse_comp (
    .clk(clk),
    .rst(rst),
    .clear(clear),
    .mse_in_valid(mse_valid),
    .mse_in_value(mse_out),
    .mse_in_ref(mse_ref),
    .mse_min_value(mse_min_value),
    .mse_min_ref(mse_min_ref),
    .mse_max_value(mse_max_value),
    .mse_max_ref(mse_max_ref),
    .mse_out_valid(mse_cmp_valid)
  );

endmodule

// File: hsid_main_fsm.sv
module hsid_main_fsm (
  input  logic clk,
  input  logic rst,
  input  logic start,  // Begin a new identification
  input  hsid_pkg::lib_size_t library_size,  // Reference vectors to process
  input  logic in_valid,  // Input word strobe
  input  logic fifo_measure_full,
  input  logic fifo_measure_empty,
  input  logic fifo_ref_full,
  input  logic fifo_ref_empty,
  input  logic mse_cmp_valid,  // Comparator finished one result
  output hsid_pkg::hsid_main_state_t state,
  output hsid_pkg::lib_ref_t vctr_count,  // Index of the vector being read
  output logic element_start,  // Word 0 of a vector
  output logic element_last,  // Final word of a vector
  output logic element_valid,  // Pair popped this cycle
  output logic fifo_both_read_en,  // Pop both FIFOs
  output logic done,
  output logic idle,
  output logic ready
);

  localparam hsid_pkg::elem_cnt_t LAST_ELEM = hsid_pkg::elem_cnt_t'(hsid_pkg::ELEMENTS - 1);

  hsid_pkg::lib_size_t lib_size_r;  // Library size captured at start
  hsid_pkg::lib_size_t last_idx;  // Index of the final vector
  hsid_pkg::elem_cnt_t in_elem_cnt;  // Accepted words in current spectrum
  hsid_pkg::lib_size_t in_vctr_cnt;  // Reference vectors fully accepted
  hsid_pkg::elem_cnt_t rd_elem_cnt;  // Popped words in current vector
  hsid_pkg::lib_size_t cmp_cnt;  // Comparator results seen
  logic in_accept;  // Input word taken this cycle
  logic rd_last_vctr;  // Reading the final vector

  assign last_idx = lib_size_r - hsid_pkg::lib_size_t'(1);
  assign rd_last_vctr = (hsid_pkg::lib_size_t'(vctr_count) == last_idx);

  // Input side flow control
  always_comb begin
    ready = 1'b0;
    if (state == hsid_pkg::READ_MEASURE) begin
      ready = !fifo_measure_full;
    end else if (state == hsid_pkg::COMPUTE_MSE) begin
      ready = !fifo_ref_full && (in_vctr_cnt != lib_size_r);  // Stop once all refs are in
    end
  end

  assign in_accept = in_valid && ready;

  // Pair read when both sides hold data
  assign fifo_both_read_en = (state == hsid_pkg::COMPUTE_MSE) && !fifo_measure_empty &&
                             !fifo_ref_empty;
  assign element_valid = fifo_both_read_en;
  assign element_start = (rd_elem_cnt == '0);
  assign element_last = (rd_elem_cnt == LAST_ELEM);

  assign idle = (state == hsid_pkg::IDLE);
  assign done = (state == hsid_pkg::DONE);  // Single cycle, DONE always falls back to IDLE

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= hsid_pkg::IDLE;
      lib_size_r <= '0;
      in_elem_cnt <= '0;
      in_vctr_cnt <= '0;
      rd_elem_cnt <= '0;
      vctr_count <= '0;
      cmp_cnt <= '0;
    end else begin
      case (state)
        hsid_pkg::IDLE: begin
          if (start) begin
            state <= hsid_pkg::READ_MEASURE;
            lib_size_r <= library_size;  // Held for the whole run
            in_elem_cnt <= '0;
            in_vctr_cnt <= '0;
            rd_elem_cnt <= '0;
            vctr_count <= '0;
            cmp_cnt <= '0;
          end
        end
        hsid_pkg::READ_MEASURE: begin
          if (in_accept) begin
            in_elem_cnt <= (in_elem_cnt == LAST_ELEM) ? '0 : in_elem_cnt + 1'b1;
            if (in_elem_cnt == LAST_ELEM) begin
              state <= hsid_pkg::COMPUTE_MSE;  // Measured spectrum complete
            end
          end
        end
        hsid_pkg::COMPUTE_MSE: begin
          if (in_accept) begin
            in_elem_cnt <= (in_elem_cnt == LAST_ELEM) ? '0 : in_elem_cnt + 1'b1;
            if (in_elem_cnt == LAST_ELEM) begin
              in_vctr_cnt <= in_vctr_cnt + 1'b1;  // One more ref fully taken
            end
          end
          if (fifo_both_read_en) begin
            if (element_last) begin
              rd_elem_cnt <= '0;
              if (rd_last_vctr) begin
                state <= hsid_pkg::WAIT_MSE;  // All pairs issued
              end else begin
                vctr_count <= vctr_count + 1'b1;
              end
            end else begin
              rd_elem_cnt <= rd_elem_cnt + 1'b1;
            end
          end
          if (mse_cmp_valid) begin
            cmp_cnt <= cmp_cnt + 1'b1;  // Earlier results finish while reading
          end
        end
        hsid_pkg::WAIT_MSE: begin
          if (mse_cmp_valid) begin
            cmp_cnt <= cmp_cnt + 1'b1;
            if (cmp_cnt == last_idx) begin
              state <= hsid_pkg::DONE;  // Final result compared
            end
          end
        end
        hsid_pkg::DONE: begin
          state <= hsid_pkg::IDLE;
        end
        default: begin
          state <= hsid_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

// File: hsid_main_tb.sv
module hsid_main_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic clk;
  logic rst;
  logic hsi_vctr_in_valid;
  hsid_pkg::word_t hsi_vctr_in;
  hsid_pkg::lib_size_t library_size_in;
  logic clear;
  logic start;
  hsid_pkg::lib_ref_t mse_min_ref;
  hsid_pkg::word_t mse_min_value;
  hsid_pkg::lib_ref_t mse_max_ref;
  hsid_pkg::word_t mse_max_value;
  logic done;
  logic idle;
  logic ready;

  logic [127:0] case_name [$];  // Case names as read from the file
  int case_size [$];  // Library vectors per case
  hsid_pkg::lib_ref_t case_min_ref [$];
  hsid_pkg::word_t case_min_val [$];
  hsid_pkg::lib_ref_t case_max_ref [$];
  hsid_pkg::word_t case_max_val [$];
  hsid_pkg::word_t words [$];  // Measure then library words, all cases back to back
  int errors;
  int checks;
  int cycles;  // Cycles since the limit was set
  int limit_cycles;
  bit limit_set;

  hsid_main uut (
    .clk(clk),
    .rst(rst),
    .hsi_vctr_in_valid(hsi_vctr_in_valid),
    .hsi_vctr_in(hsi_vctr_in),
    .library_size_in(library_size_in),
    .clear(clear),
    .start(start),
    .mse_min_ref(mse_min_ref),
    .mse_min_value(mse_min_value),
    .mse_max_ref(mse_max_ref),
    .mse_max_value(mse_max_value),
    .done(done),
    .idle(idle),
    .ready(ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  task automatic check_value(input string test, input hsid_pkg::word_t exp,
                             input hsid_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", test, exp, act);
    end
  endtask

  task automatic check_ref(input string test, input hsid_pkg::lib_ref_t exp,
                           input hsid_pkg::lib_ref_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %0d, actual %0d", test, exp, act);
    end
  endtask

  task automatic check_flag(input string test, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %b, actual %b", test, exp, act);
    end
  endtask

  // Next line that is neither blank nor a comment
  function automatic bit next_line(input int fd, output string line);
    bit found;
    found = 1'b0;
    line = "";
    while (!found && !$feof(fd)) begin
      if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
        found = 1'b1;  // 8'h23 is the comment hash
      end
    end
    return found;
  endfunction

  task automatic load_cases();
    int fd;
    int n;
    int k;
    int sz;
    int mnr;
    int mxr;
    string line;
    logic [127:0] nm;
    hsid_pkg::word_t mnv;
    hsid_pkg::word_t mxv;
    hsid_pkg::word_t w [4];
    fd = $fopen("hsid_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open hsid_cases.txt");
    end else begin
      while (next_line(fd, line)) begin
        n = $sscanf(line, "%s %d %d %h %d %h", nm, sz, mnr, mnv, mxr, mxv);  // Case header
        if (n != 6) begin
          errors++;
          $display("malformed case header in hsid_cases.txt");
        end
        case_name.push_back(nm);
        case_size.push_back(sz);
        case_min_ref.push_back(hsid_pkg::lib_ref_t'(mnr));
        case_min_val.push_back(mnv);
        case_max_ref.push_back(hsid_pkg::lib_ref_t'(mxr));
        case_max_val.push_back(mxv);
        for (k = 0; k <= sz; k++) begin  // Measured spectrum plus sz references
          void'(next_line(fd, line));
          n = $sscanf(line, "%h %h %h %h", w[0], w[1], w[2], w[3]);
          if (n != 4) begin
            errors++;
            $display("spectrum line with fewer than four words in hsid_cases.txt");
          end
          foreach (w[i]) words.push_back(w[i]);
        end
      end
      $fclose(fd);
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the strobe
  task automatic send_word(input hsid_pkg::word_t w);
    int gap;
    gap = int'($urandom % 4);  // 0 to 3 idle cycles
    repeat (gap) @(negedge clk);
    while (!ready) @(negedge clk);  // Hold the word while back-pressured
    hsi_vctr_in = w;
    hsi_vctr_in_valid = 1'b1;
    @(negedge clk);
    hsi_vctr_in_valid = 1'b0;
  endtask

  task automatic run_case(input int c, input int base);
    string nm;
    int k;
    nm = $sformatf("%0s", case_name[c]);
    clear = 1'b1;  // Drop the extremes of the previous case
    @(negedge clk);
    clear = 1'b0;
    library_size_in = hsid_pkg::lib_size_t'(case_size[c]);  // Held until done
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    for (k = 0; k < (case_size[c] + 1) * hsid_pkg::ELEMENTS; k++) begin
      send_word(words[base + k]);
    end
    while (!done) @(negedge clk);
    check_value({nm, " min value"}, case_min_val[c], mse_min_value);
    check_ref({nm, " min ref"}, case_min_ref[c], mse_min_ref);
    check_value({nm, " max value"}, case_max_val[c], mse_max_value);
    check_ref({nm, " max ref"}, case_max_ref[c], mse_max_ref);
    check_flag({nm, " ready at done"}, 1'b0, ready);  // All words already taken
    @(negedge clk);
    check_flag({nm, " done after one cycle"}, 1'b0, done);
    check_flag({nm, " idle after done"}, 1'b1, idle);
  endtask

  initial begin
    int base;
    rst = 1'b1;
    hsi_vctr_in_valid = 1'b0;
    hsi_vctr_in = '0;
    library_size_in = '0;
    clear = 1'b0;
    start = 1'b0;
    errors = 0;
    checks = 0;
    limit_set = 1'b0;
    void'($urandom(32'hd0e3));
    load_cases();
    limit_cycles = words.size() * 6 + 100 * case_name.size();
    limit_set = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_flag("reset idle", 1'b1, idle);
    check_flag("reset done", 1'b0, done);
    check_flag("reset ready", 1'b0, ready);
    base = 0;
    foreach (case_name[c]) begin
      run_case(c, base);
      base += (case_size[c] + 1) * hsid_pkg::ELEMENTS;  // Words of this case
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Run limit from the word count in the file
  initial begin
    cycles = 0;
    wait (limit_set);
    while (cycles < limit_cycles) begin
      @(posedge clk);
      cycles++;
    end
    errors++;
    $display("timeout after %0d cycles, done never arrived", cycles);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("tests failed");
    $finish;
  end

endmodule

// File: hsid_mse.sv
module hsid_mse (
  input  logic clk,
  input  logic rst,
  input  logic element_valid,  // Word pair present
  input  logic element_start,  // First pair of a vector
  input  logic element_last,  // Final pair of a vector
  input  hsid_pkg::lib_ref_t vctr_ref,  // Library index of the pair
  input  hsid_pkg::word_t element_a,  // Measured word
  input  hsid_pkg::word_t element_b,  // Reference word
  output hsid_pkg::word_t mse_value,
  output hsid_pkg::lib_ref_t mse_ref,
  output logic mse_valid  // One cycle per vector
);

  hsid_pkg::sample_t diff_lo;  // Even band distance
  hsid_pkg::sample_t diff_hi;  // Odd band distance
  hsid_pkg::word_t sq_lo;
  hsid_pkg::word_t sq_hi;
  hsid_pkg::acc_t sq_sum;  // Both squares for this word

  hsid_pkg::acc_t s1_sum;  // Stage one payload
  hsid_pkg::lib_ref_t s1_ref;
  logic s1_valid;
  logic s1_start;
  logic s1_last;

  hsid_pkg::acc_t acc;  // Running sum for a vector
  hsid_pkg::lib_ref_t s2_ref;
  logic s2_drain;  // Accumulator holds a finished vector

  always_comb begin
    // Unsigned samples so take the absolute difference
    diff_lo = (element_a[15:0] >= element_b[15:0]) ? element_a[15:0] - element_b[15:0] :
                                                     element_b[15:0] - element_a[15:0];
    diff_hi = (element_a[31:16] >= element_b[31:16]) ? element_a[31:16] - element_b[31:16] :
                                                       element_b[31:16] - element_a[31:16];
    sq_lo = hsid_pkg::word_t'(diff_lo) * hsid_pkg::word_t'(diff_lo);
    sq_hi = hsid_pkg::word_t'(diff_hi) * hsid_pkg::word_t'(diff_hi);
    sq_sum = hsid_pkg::acc_t'(sq_lo) + hsid_pkg::acc_t'(sq_hi);
  end

  always_ff @(posedge clk) begin
    s1_sum <= sq_sum;
    s1_ref <= vctr_ref;
    if (s1_valid) begin
      acc <= s1_start ? s1_sum : acc + s1_sum;  // Restart on a new vector
      s2_ref <= s1_ref;
    end
    if (s2_drain) begin
      mse_value <= hsid_pkg::word_t'(acc >> $clog2(hsid_pkg::HSI_BANDS));  // Mean by shift
      mse_ref <= s2_ref;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s1_start <= 1'b0;
      s1_last <= 1'b0;
      s2_drain <= 1'b0;
      mse_valid <= 1'b0;
    end else begin
      s1_valid <= element_valid;
      s1_start <= element_start;
      s1_last <= element_last;
      s2_drain <= s1_valid && s1_last;  // Last word added this edge
      mse_valid <= s2_drain;
    end
  end

endmodule

// File: hsid_mse_comp.sv
module hsid_mse_comp (
  input  logic clk,
  input  logic rst,
  input  logic clear,  // Drop stored extremes
  input  logic mse_in_valid,
  input  hsid_pkg::word_t mse_in_value,
  input  hsid_pkg::lib_ref_t mse_in_ref,
  output hsid_pkg::word_t mse_min_value,
  output hsid_pkg::lib_ref_t mse_min_ref,
  output hsid_pkg::word_t mse_max_value,
  output hsid_pkg::lib_ref_t mse_max_ref,
  output logic mse_out_valid  // Pulses after the extremes settle
);

  logic updated;  // Extremes took a result last edge

  // Extremes and their indices
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      mse_min_value <= '1;  // Any result is below this
      mse_min_ref <= '0;
      mse_max_value <= '0;
      mse_max_ref <= '0;
    end else if (mse_in_valid) begin
      if (mse_in_value < mse_min_value) begin
        mse_min_value <= mse_in_value;  // Strict so ties keep the older index
        mse_min_ref <= mse_in_ref;
      end
      if (mse_in_value > mse_max_value) begin
        mse_max_value <= mse_in_value;
        mse_max_ref <= mse_in_ref;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      updated <= 1'b0;
      mse_out_valid <= 1'b0;
    end else begin
      updated <= mse_in_valid && !clear;  // Clear wins over a result
      mse_out_valid <= updated;
    end
  end

endmodule

// File: hsid_pkg.sv
package hsid_pkg;

  // Stream and spectrum sizes
  localparam int WORD_WIDTH = 32;  // Bits per stream word
  localparam int DATA_WIDTH = 16;  // Bits per band sample
  localparam int HSI_BANDS = 8;  // Bands in one spectrum
  localparam int ELEMENTS = HSI_BANDS / 2;  // Two samples per word
  localparam int BUFFER_LENGTH = 4;  // Reference FIFO depth
  localparam int HSI_LIBRARY_SIZE = 16;  // Max reference vectors
  localparam int LIB_ADDR = $clog2(HSI_LIBRARY_SIZE);  // Library index width

  // Stream word, also used for the MSE value
  typedef logic [WORD_WIDTH-1:0] word_t;

  typedef logic [DATA_WIDTH-1:0] sample_t;  // Unsigned band sample

  typedef logic [LIB_ADDR-1:0] lib_ref_t;  // Library index

  // One extra bit so a full library count fits
  typedef logic [LIB_ADDR:0] lib_size_t;

  typedef logic [39:0] acc_t;  // Squared error sum, wide enough for all bands

  typedef logic [$clog2(ELEMENTS)-1:0] elem_cnt_t;  // Word position in a spectrum

  // Controller states
  typedef enum logic [2:0] {
    IDLE,  // Waiting for start
    READ_MEASURE,  // Loading the measured spectrum
    COMPUTE_MSE,  // Streaming references through the MSE unit
    WAIT_MSE,  // Draining the last results
    DONE  // One cycle done strobe
  } hsid_main_state_t;

endpackage
